/* tb.f */
+incdir+common
+incdir+test
common/mips_pkg.sv
execute/mips_alu.sv
decode/mips_control.sv
verilog/mips_register_file.sv
verilog/mips_next_pc.sv
verilog/mips_writeback.sv
verilog/mips_cpu_harvard.sv
test/tb_mips_cpu.sv

/* Bender.yml */
package:
  name: mips_cpu_harvard

sources:
  - include_dirs:
      - common
    files:
      - common/mips_pkg.sv
      - execute/mips_alu.sv
      - decode/mips_control.sv
      - verilog/mips_register_file.sv
      - verilog/mips_next_pc.sv
      - verilog/mips_writeback.sv
      - verilog/mips_cpu_harvard.sv
  - target: test
    include_dirs:
      - common
      - test
    files:
      - test/tb_mips_cpu.sv

/* test/tb_mips_ref.svh */
`ifndef TB_MIPS_REF_SVH
`define TB_MIPS_REF_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shadow state, stepped once per enabled edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
mips_pkg::word_t ref_regs [`MIPS_NUM_REGS];
mips_pkg::word_t ref_dmem [dmem_words];
mips_pkg::word_t ref_pc;
logic            exp_store;
logic            exp_load;
mips_pkg::word_t exp_addr;
mips_pkg::word_t exp_data;

// executes one instruction, no delay slot
function automatic void ref_step(input mips_pkg::word_t instr);
	logic [5:0]          op;
	logic [5:0]          fn;
	logic [7:0]          lb;
	logic [15:0]         lh;
	mips_pkg::reg_addr_t dst;
	mips_pkg::word_t     a, b, simm, zimm, res, addr, mem, next;
	logic                wr;
	op   = instr[31:26];
	fn   = instr[5:0];
	a    = ref_regs[instr[25:21]];
	b    = ref_regs[instr[20:16]];
	simm = {{16{instr[15]}}, instr[15:0]};
	zimm = {16'h0000, instr[15:0]};
	addr = a + simm;
	mem  = ref_dmem[addr[7:2]];
	lb   = mem[8 * addr[1:0] +: 8];
	lh   = mem[16 * addr[1] +: 16];
	next = ref_pc + 32'd4;
	dst  = instr[20:16];
	res  = '0;
	exp_store = 1'b0;
	exp_load  = 1'b0;
	exp_addr  = addr;
	exp_data  = b;
	if (ref_pc == `MIPS_HALT_ADDR)
		return; // halted core does nothing
	wr = op inside {mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU,
		mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI,
		mips_pkg::OP_LW, mips_pkg::OP_LB, mips_pkg::OP_LBU, mips_pkg::OP_LH, mips_pkg::OP_LHU};
	case (op)
		mips_pkg::OP_SPECIAL: begin
			dst = instr[15:11];
			wr  = 1'b1;
			case (fn)
				mips_pkg::FN_SLL:  res = b << instr[10:6];
				mips_pkg::FN_SRL:  res = b >> instr[10:6];
				mips_pkg::FN_SRA:  res = $signed(b) >>> instr[10:6];
				mips_pkg::FN_SLLV: res = b << a[4:0];
				mips_pkg::FN_SRLV: res = b >> a[4:0];
				mips_pkg::FN_SRAV: res = $signed(b) >>> a[4:0];
				mips_pkg::FN_JR: begin
					next = a;
					wr   = 1'b0;
				end
				mips_pkg::FN_JALR: begin
					next = a;
					res  = ref_pc + 32'd4;
				end
				mips_pkg::FN_ADDU: res = a + b;
				mips_pkg::FN_SUBU: res = a - b;
				mips_pkg::FN_AND:  res = a & b;
				mips_pkg::FN_OR:   res = a | b;
				mips_pkg::FN_XOR:  res = a ^ b;
				mips_pkg::FN_NOR:  res = ~(a | b);
				mips_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				mips_pkg::FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
				default:           wr = 1'b0;
			endcase
		end
		mips_pkg::OP_J:   next = {ref_pc[31:28], instr[25:0], 2'b00};
		mips_pkg::OP_JAL: begin
			next = {ref_pc[31:28], instr[25:0], 2'b00};
			dst  = 5'd31;
			res  = ref_pc + 32'd4;
			wr   = 1'b1;
		end
		mips_pkg::OP_BEQ:   next = (a == b) ? next + {simm[29:0], 2'b00} : next;
		mips_pkg::OP_BNE:   next = (a != b) ? next + {simm[29:0], 2'b00} : next;
		mips_pkg::OP_ADDIU: res = a + simm;
		mips_pkg::OP_SLTI:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
		mips_pkg::OP_SLTIU: res = (a < simm) ? 32'd1 : 32'd0; // unsigned, sign-extended imm
		mips_pkg::OP_ANDI:  res = a & zimm;
		mips_pkg::OP_ORI:   res = a | zimm;
		mips_pkg::OP_XORI:  res = a ^ zimm;
		mips_pkg::OP_LUI:   res = {instr[15:0], 16'h0000};
		mips_pkg::OP_LW:    res = mem;
		mips_pkg::OP_LB:    res = {{24{lb[7]}}, lb};
		mips_pkg::OP_LBU:   res = {24'h000000, lb};
		mips_pkg::OP_LH:    res = {{16{lh[15]}}, lh};
		mips_pkg::OP_LHU:   res = {16'h0000, lh};
		mips_pkg::OP_SW: begin
			exp_store = 1'b1;
			ref_dmem[addr[7:2]] = b;
		end
		default: ;
	endcase
	exp_load = op inside {mips_pkg::OP_LW, mips_pkg::OP_LB, mips_pkg::OP_LBU,
		mips_pkg::OP_LH, mips_pkg::OP_LHU};
	if (wr && dst != 5'd0)
		ref_regs[dst] = res;
	ref_pc = next;
endfunction

`endif

/* test/tb_mips_cpu.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module tb_mips_cpu;

	localparam int imem_words = 256;
	localparam int dmem_words = 64;
	localparam int run_limit  = 4000; // cycles per program
	localparam int halt_watch = 24;
	localparam logic [5:0] alu_functs [14] = '{mips_pkg::FN_SLL, mips_pkg::FN_SRL,
		mips_pkg::FN_SRA, mips_pkg::FN_SLLV, mips_pkg::FN_SRLV, mips_pkg::FN_SRAV,
		mips_pkg::FN_ADDU, mips_pkg::FN_SUBU, mips_pkg::FN_AND, mips_pkg::FN_OR,
		mips_pkg::FN_XOR, mips_pkg::FN_NOR, mips_pkg::FN_SLT, mips_pkg::FN_SLTU};
	localparam logic [5:0] imm_ops [7] = '{mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI,
		mips_pkg::OP_SLTIU, mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI,
		mips_pkg::OP_LUI};

	logic            clk;
	logic            rst_n;
	logic            clk_enable;
	logic            active;
	logic            data_write;
	logic            data_read;
	logic            reset_taken;
	mips_pkg::word_t register_v0;
	mips_pkg::word_t instr_address;
	mips_pkg::word_t instr_readdata;
	mips_pkg::word_t data_address;
	mips_pkg::word_t data_writedata;
	mips_pkg::word_t data_readdata;
	mips_pkg::word_t imem_off;
	mips_pkg::word_t halt_instr; // fetched once the pc leaves the program
	mips_pkg::word_t imem [imem_words];
	mips_pkg::word_t dmem [dmem_words];
	int              prog_len;
	int              stall_left;
	int              mismatches;
	int              failures;
	logic            timed_out;

	`include "tb_mips_ref.svh"

	mips_cpu_harvard u_mips_cpu_harvard (
		.clk            (clk),
		.rst_n          (rst_n),
		.active         (active),
		.register_v0    (register_v0),
		.clk_enable     (clk_enable),
		.instr_address  (instr_address),
		.instr_readdata (instr_readdata),
		.data_address   (data_address),
		.data_write     (data_write),
		.data_read      (data_read),
		.data_writedata (data_writedata),
		.data_readdata  (data_readdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memories
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign imem_off       = instr_address - `MIPS_RESET_VECTOR;
	assign instr_readdata = (imem_off < 4 * imem_words) ? imem[imem_off[9:2]] : halt_instr;
	assign data_readdata  = dmem[data_address[7:2]];

	always @(posedge clk) begin
		if (data_write && clk_enable)
			dmem[data_address[7:2]] <= data_writedata;
		reset_taken <= !rst_n; // pc is at the reset vector after this edge
	end

	function automatic mips_pkg::word_t fetch_at(input mips_pkg::word_t addr);
		mips_pkg::word_t off;
		off = addr - `MIPS_RESET_VECTOR;
		return (off < 4 * imem_words) ? imem[off[9:2]] : halt_instr;
	endfunction

	function automatic mips_pkg::word_t fill_word(input int i);
		return {8'(i), ~8'(i), 8'(i * 7 + 1), 8'h5A ^ 8'(i)};
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// assembler
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic mips_pkg::word_t enc_r(input logic [5:0] fn, input int rs, rt, rd, sh);
		return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
	endfunction

	function automatic mips_pkg::word_t enc_i(input logic [5:0] op, input int rs, rt,
		input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic mips_pkg::word_t enc_j(input logic [5:0] op, input mips_pkg::word_t target);
		return {op, target[27:2]};
	endfunction

	function automatic mips_pkg::word_t pc_at(input int idx);
		return `MIPS_RESET_VECTOR + 4 * idx;
	endfunction

	function automatic int pick_reg();
		return ($urandom_range(0, 1) == 1) ? 2 : $urandom_range(8, 11); // favour $v0
	endfunction

	task automatic emit(input mips_pkg::word_t w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic load_value(input int r, input mips_pkg::word_t value);
		emit(enc_i(mips_pkg::OP_LUI, 0, r, value[31:16]));
		emit(enc_i(mips_pkg::OP_ORI, r, r, value[15:0]));
	endtask

	task automatic build_arith();
		int kind;
		for (int r = 8; r < 12; r++)
			load_value(r, $urandom);
		for (int i = 0; i < 60; i++) begin
			kind = $urandom_range(0, 20);
			if (kind < 14)
				emit(enc_r(alu_functs[kind], pick_reg(), pick_reg(), pick_reg(),
					(kind < 3) ? $urandom_range(0, 31) : 0));
			else
				emit(enc_i(imm_ops[kind - 14], pick_reg(), pick_reg(), 16'($urandom)));
		end
	endtask

	task automatic build_memory();
		int base;
		emit(enc_i(mips_pkg::OP_SW, 0, 0, 16'h0000)); // store fetched while in reset
		for (int i = 0; i < 6; i++) begin
			base = 4 * $urandom_range(0, dmem_words - 1);
			load_value(8, $urandom);
			emit(enc_i(mips_pkg::OP_SW, 0, 8, 16'(base)));
			emit(enc_i(mips_pkg::OP_LW, 0, 2, 16'(base)));
			for (int off = 0; off < 4; off++) begin
				emit(enc_i(mips_pkg::OP_LB, 0, 2, 16'(base + off)));
				emit(enc_i(mips_pkg::OP_LBU, 0, 2, 16'(base + off)));
				emit(enc_i(mips_pkg::OP_LH, 0, 2, 16'(base + off)));
				emit(enc_i(mips_pkg::OP_LHU, 0, 2, 16'(base + off)));
			end
			emit(enc_i(mips_pkg::OP_SW, 0, 2, 16'(4 * $urandom_range(0, dmem_words - 1))));
		end
	endtask

	task automatic build_control();
		int loop_top;
		emit(enc_i(mips_pkg::OP_LW, 0, 0, 16'h0000)); // load fetched while in reset
		emit(enc_i(mips_pkg::OP_ORI, 0, 8, 16'd5));
		emit(enc_i(mips_pkg::OP_ORI, 0, 9, 16'd5));
		emit(enc_i(mips_pkg::OP_ORI, 0, 10, 16'($urandom_range(6, 99))));
		emit(enc_i(mips_pkg::OP_BEQ, 8, 9, 16'd1));   // taken
		emit(enc_i(mips_pkg::OP_ADDIU, 2, 2, 16'h1));
		emit(enc_i(mips_pkg::OP_BEQ, 8, 10, 16'd1));  // not taken
		emit(enc_i(mips_pkg::OP_ADDIU, 2, 2, 16'h2));
		emit(enc_i(mips_pkg::OP_BNE, 8, 10, 16'd1));  // taken
		emit(enc_i(mips_pkg::OP_ADDIU, 2, 2, 16'h4));
		emit(enc_i(mips_pkg::OP_BNE, 8, 9, 16'd1));   // not taken
		emit(enc_i(mips_pkg::OP_ADDIU, 2, 2, 16'h8));
		emit(enc_j(mips_pkg::OP_J, pc_at(prog_len + 2)));
		emit(enc_i(mips_pkg::OP_ADDIU, 2, 2, 16'h10));
		emit(enc_j(mips_pkg::OP_JAL, pc_at(prog_len + 2)));
		emit(enc_i(mips_pkg::OP_ADDIU, 2, 2, 16'h20));
		emit(enc_r(mips_pkg::FN_ADDU, 31, 0, 2, 0));  // link into v0
		load_value(11, pc_at(prog_len + 4));
		emit(enc_r(mips_pkg::FN_JALR, 11, 0, 12, 0));
		emit(enc_i(mips_pkg::OP_ADDIU, 2, 2, 16'h40));
		emit(enc_r(mips_pkg::FN_ADDU, 12, 0, 2, 0));
		// short backward loop
		emit(enc_i(mips_pkg::OP_ORI, 0, 8, 16'($urandom_range(1, 6))));
		loop_top = prog_len;
		emit(enc_i(mips_pkg::OP_ADDIU, 2, 2, 16'h3));
		emit(enc_i(mips_pkg::OP_ADDIU, 8, 8, 16'hFFFF));
		emit(enc_i(mips_pkg::OP_BNE, 8, 0, 16'(loop_top - (prog_len + 1))));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic check_word(input string name, input mips_pkg::word_t got,
		input mips_pkg::word_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	// sampled mid-cycle where outputs are stable
	initial begin
		forever begin
			@(negedge clk);
			if (!rst_n) begin
				check_bit("data_write", data_write, 1'b0);
				check_bit("data_read", data_read, 1'b0);
				if (reset_taken) begin
					check_bit("active", active, 1'b1);
					check_word("instr_address", instr_address, `MIPS_RESET_VECTOR);
				end
			end else begin
				check_word("instr_address", instr_address, ref_pc);
				check_word("register_v0", register_v0, ref_regs[2]);
				check_bit("active", active, ref_pc != `MIPS_HALT_ADDR);
				if (clk_enable) begin
					ref_step(fetch_at(ref_pc));
					check_bit("data_write", data_write, exp_store);
					check_bit("data_read", data_read, exp_load);
					if (exp_store) begin
						check_word("data_address", data_address, exp_addr);
						check_word("data_writedata", data_writedata, exp_data);
					end
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic apply_reset();
		rst_n      = 1'b0;
		clk_enable = 1'b1;
		stall_left = 0;
		for (int i = 0; i < `MIPS_NUM_REGS; i++)
			ref_regs[i] = '0;
		for (int i = 0; i < dmem_words; i++) begin
			dmem[i]     = fill_word(i);
			ref_dmem[i] = fill_word(i);
		end
		ref_pc = `MIPS_RESET_VECTOR;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	// random stall stretches
	task automatic drive_enable();
		if (stall_left > 0) begin
			clk_enable = 1'b0;
			stall_left--;
		end else if ($urandom_range(0, 9) == 0) begin
			clk_enable = 1'b0;
			stall_left = $urandom_range(0, 4);
		end else begin
			clk_enable = 1'b1;
		end
	endtask

	task automatic run_program(input int kind);
		int cycles;
		prog_len = 0;
		foreach (imem[i])
			imem[i] = '0;
		case (kind)
			0:       build_arith();
			1:       build_memory();
			default: build_control();
		endcase
		emit(enc_r(mips_pkg::FN_JR, 0, 0, 0, 0)); // jr $0 ends the program
		// a halted core must ignore this store or $v0 update
		halt_instr = (kind == 1) ? enc_i(mips_pkg::OP_SW, 0, 2, 16'h0000)
			: enc_i(mips_pkg::OP_ADDIU, 2, 2, 16'h0001);
		apply_reset();
		cycles = 0;
		while (active && cycles < run_limit) begin
			@(posedge clk);
			#1;
			drive_enable();
			cycles++;
		end
		if (active) begin
			failures++;
			timed_out = 1'b1;
			$display("Program %0d did not halt within %0d cycles", kind, run_limit);
		end
		clk_enable = 1'b1;
		repeat (halt_watch) @(posedge clk); // nothing may move after halt
		#1;
	endtask

	initial begin
		void'($urandom(5446));
		rst_n      = 1'b0;
		clk_enable = 1'b0;
		mismatches = 0;
		failures   = 0;
		timed_out  = 1'b0;
		prog_len   = 0;
		stall_left = 0;
		for (int p = 0; p < 3 && !timed_out; p++)
			run_program(p);
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* verilog/mips_cpu_harvard.sv */
`timescale 1ns/1ps

module mips_cpu_harvard (
	input  logic            clk,
	input  logic            rst_n,
	output logic            active,
	output mips_pkg::word_t register_v0,

	input  logic            clk_enable,

	output mips_pkg::word_t instr_address,
	input  mips_pkg::word_t instr_readdata,

	output mips_pkg::word_t data_address,
	output logic            data_write,
	output logic            data_read,
	output mips_pkg::word_t data_writedata,
	input  mips_pkg::word_t data_readdata
);

	mips_pkg::alu_op_e    alu_op;
	mips_pkg::wb_sel_e    wb_sel;
	mips_pkg::load_kind_e load_kind;
	logic alu_src_imm, shift_var, imm_zero_ext;
	logic reg_dst, reg_write;
	logic branch, branch_ne, jump, jump_reg;
	logic eq;
	logic run_en;
	mips_pkg::word_t alu_result, rs_val, rt_val;
	mips_pkg::word_t pc_plus8_link; // return address, pc+4 as there is no delay slot
	mips_pkg::reg_addr_t wr_addr;
	mips_pkg::word_t wr_data;
	logic wr_en;

	// no side effects while in reset or after halt
	assign run_en = active & rst_n;

	assign data_address   = alu_result;
	assign data_writedata = rt_val;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	mips_control u_control (
		.instr        (instr_readdata),
		.active       (run_en),
		.alu_op       (alu_op),
		.alu_src_imm  (alu_src_imm),
		.shift_var    (shift_var),
		.imm_zero_ext (imm_zero_ext),
		.reg_dst      (reg_dst),
		.reg_write    (reg_write),
		.wb_sel       (wb_sel),
		.load_kind    (load_kind),
		.mem_read     (data_read),
		.mem_write    (data_write),
		.branch       (branch),
		.branch_ne    (branch_ne),
		.jump         (jump),
		.jump_reg     (jump_reg)
	);

	mips_register_file u_register_file (
		.clk        (clk),
		.rst_n      (rst_n),
		.clk_enable (clk_enable),
		.rd_addr_a  (instr_readdata[25:21]),
		.rd_addr_b  (instr_readdata[20:16]),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.wr_en      (wr_en),
		.rd_data_a  (rs_val),
		.rd_data_b  (rt_val),
		.v0         (register_v0)
	);

	mips_alu u_alu (
		.rs_val       (rs_val),
		.rt_val       (rt_val),
		.instr        (instr_readdata),
		.alu_op       (alu_op),
		.alu_src_imm  (alu_src_imm),
		.shift_var    (shift_var),
		.imm_zero_ext (imm_zero_ext),
		.result       (alu_result),
		.eq           (eq)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	mips_next_pc u_next_pc (
		.clk        (clk),
		.rst_n      (rst_n),
		.clk_enable (clk_enable),
		.instr      (instr_readdata),
		.rs_val     (rs_val),
		.eq         (eq),
		.branch     (branch),
		.branch_ne  (branch_ne),
		.jump       (jump),
		.jump_reg   (jump_reg),
		.pc         (instr_address),
		.link_addr  (pc_plus8_link),
		.active     (active)
	);

	mips_writeback u_writeback (
		.instr      (instr_readdata),
		.alu_result (alu_result),
		.mem_data   (data_readdata),
		.link_addr  (pc_plus8_link),
		.reg_dst    (reg_dst),
		.reg_write  (reg_write),
		.wb_sel     (wb_sel),
		.load_kind  (load_kind),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.wr_en      (wr_en)
	);

endmodule

/* verilog/mips_writeback.sv */
`timescale 1ns/1ps

module mips_writeback (
	input  mips_pkg::word_t      instr,
	input  mips_pkg::word_t      alu_result,
	input  mips_pkg::word_t      mem_data,
	input  mips_pkg::word_t      link_addr,
	input  logic                 reg_dst,
	input  logic                 reg_write,
	input  mips_pkg::wb_sel_e    wb_sel,
	input  mips_pkg::load_kind_e load_kind,
	output mips_pkg::reg_addr_t  wr_addr,
	output mips_pkg::word_t      wr_data,
	output logic                 wr_en
);

	logic [7:0]      ld_byte;
	logic [15:0]     ld_half;
	mips_pkg::word_t load_val;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// load lane select, little endian lanes
	always_comb begin
		case (alu_result[1:0])
			2'd0:    ld_byte = mem_data[7:0];
			2'd1:    ld_byte = mem_data[15:8];
			2'd2:    ld_byte = mem_data[23:16];
			default: ld_byte = mem_data[31:24];
		endcase
		ld_half = alu_result[1] ? mem_data[31:16] : mem_data[15:0];

		case (load_kind)
			mips_pkg::LD_BYTE:   load_val = {{24{ld_byte[7]}}, ld_byte};
			mips_pkg::LD_BYTE_U: load_val = {24'b0, ld_byte};
			mips_pkg::LD_HALF:   load_val = {{16{ld_half[15]}}, ld_half};
			mips_pkg::LD_HALF_U: load_val = {16'b0, ld_half};
			default:             load_val = mem_data;
		endcase
	end

	always_comb begin
		case (wb_sel)
			mips_pkg::WB_MEM:  wr_data = load_val;
			mips_pkg::WB_LINK: wr_data = link_addr;
			default:           wr_data = alu_result;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// jal links to $31, jalr to rd
	always_comb begin
		if (wb_sel == mips_pkg::WB_LINK && !reg_dst)
			wr_addr = 5'd31;
		else if (reg_dst)
			wr_addr = instr[15:11];
		else
			wr_addr = instr[20:16];
	end

	assign wr_en = reg_write && (wr_addr != '0); // $0 never written

endmodule

/* verilog/mips_next_pc.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_next_pc (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            clk_enable,
	input  mips_pkg::word_t instr,
	input  mips_pkg::word_t rs_val,
	input  logic            eq,
	input  logic            branch,
	input  logic            branch_ne,
	input  logic            jump,
	input  logic            jump_reg,
	output mips_pkg::word_t pc,
	output mips_pkg::word_t link_addr,
	output logic            active
);

	mips_pkg::word_t pc_plus4;
	mips_pkg::word_t branch_off;
	mips_pkg::word_t next_pc;
	logic take_branch;

	assign pc_plus4    = pc + 32'd4;
	assign branch_off  = {{14{instr[15]}}, instr[15:0], 2'b00};
	assign take_branch = branch && (eq != branch_ne); // bne inverts the compare

	always_comb begin
		if (jump_reg)
			next_pc = rs_val;
		else if (jump)
			next_pc = {pc[31:28], instr[25:0], 2'b00};
		else if (take_branch)
			next_pc = pc_plus4 + branch_off;
		else
			next_pc = pc_plus4;
	end

	// pc parks at the halt address
	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= `MIPS_RESET_VECTOR;
		else if (clk_enable && active)
			pc <= next_pc;
	end

	assign active    = (pc != `MIPS_HALT_ADDR);
	assign link_addr = pc_plus4;

endmodule

/* verilog/mips_register_file.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_register_file (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                clk_enable,
	input  mips_pkg::reg_addr_t rd_addr_a,
	input  mips_pkg::reg_addr_t rd_addr_b,
	input  mips_pkg::reg_addr_t wr_addr,
	input  mips_pkg::word_t     wr_data,
	input  logic                wr_en,
	output mips_pkg::word_t     rd_data_a,
	output mips_pkg::word_t     rd_data_b,
	output mips_pkg::word_t     v0
);

	mips_pkg::word_t regs [1:`MIPS_NUM_REGS-1]; // $0 not stored

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < `MIPS_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (clk_enable && wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
	assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

	assign v0 = regs[2];

endmodule

/* decode/mips_control.sv */
`timescale 1ns/1ps

module mips_control (
	input  mips_pkg::word_t      instr,
	input  logic                 active,
	output mips_pkg::alu_op_e    alu_op,
	output logic                 alu_src_imm,
	output logic                 shift_var,
	output logic                 imm_zero_ext,
	output logic                 reg_dst,
	output logic                 reg_write,
	output mips_pkg::wb_sel_e    wb_sel,
	output mips_pkg::load_kind_e load_kind,
	output logic                 mem_read,
	output logic                 mem_write,
	output logic                 branch,
	output logic                 branch_ne,
	output logic                 jump,
	output logic                 jump_reg
);

	mips_pkg::opcode_e opcode;
	mips_pkg::funct_e  funct;
	logic reg_write_raw, mem_read_raw, mem_write_raw;

	assign opcode = mips_pkg::opcode_e'(instr[31:26]);
	assign funct  = mips_pkg::funct_e'(instr[5:0]);

	always_comb begin
		// defaults make a no-op
		alu_op        = mips_pkg::ALU_ADD;
		alu_src_imm   = 1'b0;
		shift_var     = 1'b0;
		imm_zero_ext  = 1'b0;
		reg_dst       = 1'b0;
		reg_write_raw = 1'b0;
		wb_sel        = mips_pkg::WB_ALU;
		load_kind     = mips_pkg::LD_WORD;
		mem_read_raw  = 1'b0;
		mem_write_raw = 1'b0;
		branch        = 1'b0;
		branch_ne     = 1'b0;
		jump          = 1'b0;
		jump_reg      = 1'b0;

		case (opcode)
			mips_pkg::OP_SPECIAL: begin
				reg_dst       = 1'b1;
				reg_write_raw = 1'b1;
				case (funct)
					mips_pkg::FN_SLL:  alu_op = mips_pkg::ALU_SLL;
					mips_pkg::FN_SRL:  alu_op = mips_pkg::ALU_SRL;
					mips_pkg::FN_SRA:  alu_op = mips_pkg::ALU_SRA;
					mips_pkg::FN_SLLV: begin
						alu_op    = mips_pkg::ALU_SLL;
						shift_var = 1'b1;
					end
					mips_pkg::FN_SRLV: begin
						alu_op    = mips_pkg::ALU_SRL;
						shift_var = 1'b1;
					end
					mips_pkg::FN_SRAV: begin
						alu_op    = mips_pkg::ALU_SRA;
						shift_var = 1'b1;
					end
					mips_pkg::FN_JR: begin
						jump_reg      = 1'b1;
						reg_write_raw = 1'b0;
					end
					mips_pkg::FN_JALR: begin
						jump_reg = 1'b1;
						wb_sel   = mips_pkg::WB_LINK; // rd gets pc+4
					end
					mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
					mips_pkg::FN_NOR:  alu_op = mips_pkg::ALU_NOR;
					mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLTU: alu_op = mips_pkg::ALU_SLTU;
					default:           reg_write_raw = 1'b0;
				endcase
			end
			mips_pkg::OP_J:   jump = 1'b1;
			mips_pkg::OP_JAL: begin
				jump          = 1'b1;
				reg_write_raw = 1'b1;
				wb_sel        = mips_pkg::WB_LINK; // reg_dst low selects $31
			end
			mips_pkg::OP_BEQ: branch = 1'b1;
			mips_pkg::OP_BNE: begin
				branch    = 1'b1;
				branch_ne = 1'b1;
			end
			mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU,
			mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI,
			mips_pkg::OP_LUI: begin
				alu_src_imm   = 1'b1;
				reg_write_raw = 1'b1;
				case (opcode)
					mips_pkg::OP_SLTI:  alu_op = mips_pkg::ALU_SLT;
					mips_pkg::OP_SLTIU: alu_op = mips_pkg::ALU_SLTU; // imm still sign extended
					mips_pkg::OP_ANDI:  alu_op = mips_pkg::ALU_AND;
					mips_pkg::OP_ORI:   alu_op = mips_pkg::ALU_OR;
					mips_pkg::OP_XORI:  alu_op = mips_pkg::ALU_XOR;
					mips_pkg::OP_LUI:   alu_op = mips_pkg::ALU_LUI;
					default:            alu_op = mips_pkg::ALU_ADD;
				endcase
				imm_zero_ext = (opcode == mips_pkg::OP_ANDI) || (opcode == mips_pkg::OP_ORI) ||
					(opcode == mips_pkg::OP_XORI);
			end
			mips_pkg::OP_LW, mips_pkg::OP_LB, mips_pkg::OP_LBU,
			mips_pkg::OP_LH, mips_pkg::OP_LHU: begin
				alu_src_imm   = 1'b1;
				reg_write_raw = 1'b1;
				mem_read_raw  = 1'b1;
				wb_sel        = mips_pkg::WB_MEM;
				case (opcode)
					mips_pkg::OP_LB:  load_kind = mips_pkg::LD_BYTE;
					mips_pkg::OP_LBU: load_kind = mips_pkg::LD_BYTE_U;
					mips_pkg::OP_LH:  load_kind = mips_pkg::LD_HALF;
					mips_pkg::OP_LHU: load_kind = mips_pkg::LD_HALF_U;
					default:          load_kind = mips_pkg::LD_WORD;
				endcase
			end
			mips_pkg::OP_SW: begin
				alu_src_imm   = 1'b1;
				mem_write_raw = 1'b1;
			end
			default: ;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// side effects only while running
	assign reg_write = reg_write_raw & active;
	assign mem_read  = mem_read_raw & active;
	assign mem_write = mem_write_raw & active;

endmodule

/* execute/mips_alu.sv */
`timescale 1ns/1ps

module mips_alu (
	input  mips_pkg::word_t   rs_val,
	input  mips_pkg::word_t   rt_val,
	input  mips_pkg::word_t   instr,
	input  mips_pkg::alu_op_e alu_op,
	input  logic              alu_src_imm,
	input  logic              shift_var,
	input  logic              imm_zero_ext,
	output mips_pkg::word_t   result,
	output logic              eq
);

	mips_pkg::word_t  imm_ext;
	mips_pkg::word_t  op_b;
	mips_pkg::shamt_t shamt;

	assign imm_ext = imm_zero_ext ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
	assign op_b    = alu_src_imm ? imm_ext : rt_val;

	// variable shifts take the low rs bits
	assign shamt = shift_var ? rs_val[4:0] : instr[10:6];

	always_comb begin
		case (alu_op)
			mips_pkg::ALU_ADD:  result = rs_val + op_b;
			mips_pkg::ALU_SUB:  result = rs_val - op_b;
			mips_pkg::ALU_AND:  result = rs_val & op_b;
			mips_pkg::ALU_OR:   result = rs_val | op_b;
			mips_pkg::ALU_XOR:  result = rs_val ^ op_b;
			mips_pkg::ALU_NOR:  result = ~(rs_val | op_b);
			mips_pkg::ALU_SLT:  result = {31'b0, $signed(rs_val) < $signed(op_b)};
			mips_pkg::ALU_SLTU: result = {31'b0, rs_val < op_b};
			mips_pkg::ALU_SLL:  result = op_b << shamt; // shifts act on rt
			mips_pkg::ALU_SRL:  result = op_b >> shamt;
			mips_pkg::ALU_SRA:  result = $signed(op_b) >>> shamt;
			mips_pkg::ALU_LUI:  result = {instr[15:0], 16'b0};
			default:            result = '0;
		endcase
	end

	// branch compare uses rt directly
	assign eq = (rs_val == rt_val);

endmodule

/* common/mips_pkg.sv */
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [4:0]  shamt_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction fields
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0A,
		OP_SLTIU   = 6'h0B,
		OP_ANDI    = 6'h0C,
		OP_ORI     = 6'h0D,
		OP_XORI    = 6'h0E,
		OP_LUI     = 6'h0F,
		OP_LB      = 6'h20,
		OP_LH      = 6'h21,
		OP_LW      = 6'h23,
		OP_LBU     = 6'h24,
		OP_LHU     = 6'h25,
		OP_SW      = 6'h2B
	} opcode_e;

	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_SRA  = 6'h03,
		FN_SLLV = 6'h04,
		FN_SRLV = 6'h06,
		FN_SRAV = 6'h07,
		FN_JR   = 6'h08,
		FN_JALR = 6'h09,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2A,
		FN_SLTU = 6'h2B
	} funct_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// datapath controls
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_e;

	typedef enum logic [2:0] {
		LD_WORD, LD_BYTE, LD_BYTE_U, LD_HALF, LD_HALF_U
	} load_kind_e;

	typedef enum logic [1:0] {
		WB_ALU, WB_MEM, WB_LINK
	} wb_sel_e;

endpackage

/* common/mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// first fetch after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// reaching this address ends the program
`define MIPS_HALT_ADDR 32'h00000000

`define MIPS_NUM_REGS 32

`endif
